// File: hdl/axi_slave_pkg.sv
// shared AXI3 slave types, single outstanding burst per direction, no wid and no interleaving
package axi_slave_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////
  localparam int mem_bytes = 128;  // internal memory, bytes
  localparam int data_w    = 32;
  localparam int strb_w    = data_w / 8;
  localparam int id_w      = 4;
  localparam int max_size  = 2;    // 4-byte beats at most

  typedef enum logic [1:0] {
    fixed    = 2'd0,
    incr     = 2'd1,
    wrap     = 2'd2,
    reserved = 2'd3
  } axi_burst_e;

  typedef enum logic [1:0] {
    okay   = 2'd0,
    slverr = 2'd2,
    decerr = 2'd3
  } axi_resp_e;

  //////////////////////////////////////////////////////////////////////
  // channel payloads
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [id_w-1:0] id;
    logic [31:0]     addr;
    logic [3:0]      len;    // beats minus one
    logic [2:0]      size;   // log2 of bytes per beat
    axi_burst_e      burst;
  } axi_cmd_t;  // shared by AW and AR

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              last;
  } axi_wbeat_t;

  typedef struct packed {
    logic [id_w-1:0] id;
    axi_resp_e       resp;
  } axi_bresp_t;

  typedef struct packed {
    logic [id_w-1:0]   id;
    logic [data_w-1:0] data;
    axi_resp_e         resp;
    logic              last;
  } axi_rbeat_t;

  // response for a whole transaction, decided once at the address handshake
  // slverr outranks decerr
  function automatic axi_resp_e cmd_resp(input axi_cmd_t cmd);
    logic bad_wrap;
    bad_wrap = (cmd.burst == wrap) && !(cmd.len inside {4'd1, 4'd3, 4'd7, 4'd15});
    if (cmd.size > max_size || cmd.burst == reserved || bad_wrap) begin
      return slverr;
    end
    if (cmd.addr >= mem_bytes) begin
      return decerr;
    end
    return okay;
  endfunction

endpackage

// File: hdl/axi_burst_addr.sv
// beat address generator, WRAP assumes len of 1/3/7/15 and a size-aligned start address
`timescale 1ns/1ps
module axi_burst_addr (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    start,      // command handshake
  input  logic                    step,       // beat handshake
  input  axi_slave_pkg::axi_cmd_t cmd,
  output logic [31:0]             beat_addr,
  output logic                    last_beat
);

  logic [31:0]               addr_q;
  logic [3:0]                len_q;
  logic [2:0]                size_q;
  axi_slave_pkg::axi_burst_e burst_q;
  logic [3:0]                count_q;    // beats already taken
  logic                      done_q;     // last beat has stepped
  logic [31:0]               step_bytes;
  logic [31:0]               incr_addr;
  logic [31:0]               wrap_mask;
  logic [31:0]               next_addr;

  always_comb begin
    step_bytes = 32'd1 << size_q;
    incr_addr  = (addr_q & ~(step_bytes - 32'd1)) + step_bytes;  // align, then advance
    wrap_mask  = (({28'd0, len_q} + 32'd1) << size_q) - 32'd1;   // wrap block minus one
    case (burst_q)
      axi_slave_pkg::fixed: next_addr = addr_q;
      axi_slave_pkg::wrap:  next_addr = (addr_q & ~wrap_mask) | (incr_addr & wrap_mask);
      default:              next_addr = incr_addr;
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      addr_q  <= '0;
      len_q   <= '0;
      size_q  <= '0;
      burst_q <= axi_slave_pkg::fixed;
      count_q <= '0;
      done_q  <= 1'b0;
    end else if (start) begin
      addr_q  <= cmd.addr;
      len_q   <= cmd.len;
      size_q  <= cmd.size;
      burst_q <= cmd.burst;
      count_q <= '0;
      done_q  <= 1'b0;
    end else if (step) begin
      addr_q  <= next_addr;
      count_q <= count_q + 4'd1;
      done_q  <= last_beat;
    end
  end

  assign beat_addr = addr_q;
  assign last_beat = (count_q == len_q);

  // a finished burst takes no more beats until the owning path restarts it
  a_no_step_after_last: assert property (@(posedge clk) disable iff (!resetn)
    step |-> !done_q);

endmodule

// File: hdl/axi_byte_mem.sv
// 32 x 32-bit byte-lane memory, no reset so contents are unknown until written
`timescale 1ns/1ps
module axi_byte_mem (
  input  logic        clk,
  input  logic        wr_en,
  input  logic [4:0]  wr_word,
  input  logic [31:0] wr_data,
  input  logic [3:0]  wr_strb,
  input  logic [4:0]  rd_word,
  output logic [31:0] rd_data
);

  logic [3:0][7:0] mem [axi_slave_pkg::mem_bytes / axi_slave_pkg::strb_w];

  //////////////////////////////////////////////////////////////////////
  // write port, one lane per strobe bit
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (wr_strb[lane]) begin
          mem[wr_word][lane] <= wr_data[8*lane +: 8];
        end
      end
    end
  end

  // read is combinational, so a write shows up after its edge
  assign rd_data = mem[rd_word];

  // the write path drops empty-strobe beats before they reach here
  a_strb_nonzero: assert property (@(posedge clk)
    wr_en |-> (wr_strb != 4'b0000));

endmodule

// File: hdl/axi_write_path.sv
// write channel FSM, one burst at a time, errored bursts drain their W beats without writing
`timescale 1ns/1ps
module axi_write_path (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      aw_valid,
  output logic                      aw_ready,
  input  axi_slave_pkg::axi_cmd_t   aw,
  input  logic                      w_valid,
  output logic                      w_ready,
  input  axi_slave_pkg::axi_wbeat_t w,
  output logic                      b_valid,
  input  logic                      b_ready,
  output axi_slave_pkg::axi_bresp_t b,
  output logic                      wr_en,
  output logic [4:0]                wr_word,
  output logic [31:0]               wr_data,
  output logic [3:0]                wr_strb
);

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_data = 2'd1,
    st_resp = 2'd2
  } wr_state_e;

  wr_state_e                                 state_q;
  logic [axi_slave_pkg::id_w-1:0]            id_q;
  axi_slave_pkg::axi_resp_e                  resp_q;
  logic                                      aw_hs;
  logic                                      w_hs;
  logic [31:0]                               beat_addr;
  logic                                      last_beat;

  assign aw_hs = aw_valid && aw_ready;
  assign w_hs  = w_valid && w_ready;

  axi_burst_addr u_addr (
    .clk       (clk),
    .resetn    (resetn),
    .start     (aw_hs),
    .step      (w_hs),
    .cmd       (aw),
    .beat_addr (beat_addr),
    .last_beat (last_beat)
  );

  //////////////////////////////////////////////////////////////////////
  // idle -> data -> resp
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state_q <= st_idle;
      resp_q  <= axi_slave_pkg::okay;
    end else begin
      case (state_q)
        st_idle: if (aw_hs) begin
          state_q <= st_data;
          resp_q  <= axi_slave_pkg::cmd_resp(aw);
        end
        st_data: if (w_hs && last_beat) state_q <= st_resp;   // counted last beat
        st_resp: if (b_ready) state_q <= st_idle;
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) id_q <= aw.id;   // echoed on B
  end

  assign aw_ready = (state_q == st_idle);
  assign w_ready  = (state_q == st_data);
  assign b_valid  = (state_q == st_resp);
  assign b        = '{id: id_q, resp: resp_q};

  // memory only sees good bursts with at least one lane
  assign wr_en   = w_hs && (resp_q == axi_slave_pkg::okay) && (|w.strb);
  assign wr_word = beat_addr[6:2];
  assign wr_data = w.data;
  assign wr_strb = w.strb;

  // master's last flag has to agree with the beat count from AW
  a_wlast_match: assert property (@(posedge clk) disable iff (!resetn)
    w_hs |-> (w.last == last_beat));

endmodule

// File: hdl/axi_read_path.sv
// read channel FSM, one burst at a time, R data comes straight from the combinational memory read
`timescale 1ns/1ps
module axi_read_path (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      ar_valid,
  output logic                      ar_ready,
  input  axi_slave_pkg::axi_cmd_t   ar,
  output logic                      r_valid,
  input  logic                      r_ready,
  output axi_slave_pkg::axi_rbeat_t r,
  output logic [4:0]                rd_word,
  input  logic [31:0]               rd_data
);

  typedef enum logic {
    st_idle = 1'b0,
    st_beat = 1'b1
  } rd_state_e;

  rd_state_e                      state_q;
  logic [axi_slave_pkg::id_w-1:0] id_q;
  axi_slave_pkg::axi_resp_e       resp_q;
  logic                           ar_hs;
  logic                           r_hs;
  logic [31:0]                    beat_addr;
  logic                           last_beat;

  assign ar_hs = ar_valid && ar_ready;
  assign r_hs  = r_valid && r_ready;

  axi_burst_addr u_addr (
    .clk       (clk),
    .resetn    (resetn),
    .start     (ar_hs),
    .step      (r_hs),
    .cmd       (ar),
    .beat_addr (beat_addr),
    .last_beat (last_beat)
  );

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state_q <= st_idle;
      resp_q  <= axi_slave_pkg::okay;
    end else if (state_q == st_idle) begin
      if (ar_hs) begin
        state_q <= st_beat;
        resp_q  <= axi_slave_pkg::cmd_resp(ar);
      end
    end else if (r_hs && last_beat) begin
      state_q <= st_idle;   // ar_ready back next cycle
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) id_q <= ar.id;
  end

  //////////////////////////////////////////////////////////////////////
  // R beat, zero data on any error
  //////////////////////////////////////////////////////////////////////
  assign ar_ready = (state_q == st_idle);
  assign r_valid  = (state_q == st_beat);
  assign rd_word  = beat_addr[6:2];
  assign r.id     = id_q;
  assign r.data   = (resp_q == axi_slave_pkg::okay) ? rd_data : '0;
  assign r.resp   = resp_q;
  assign r.last   = last_beat;

  // holds as long as no write hits the word being returned
  a_r_stable: assert property (@(posedge clk) disable iff (!resetn)
    (r_valid && !r_ready) |=> (r_valid && $stable(r)));

endmodule

// File: hdl/axi_slave_top.sv
// AXI3-style slave with 128-byte memory, one write and one read burst may run at once
`timescale 1ns/1ps
module axi_slave_top (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      aw_valid,
  output logic                      aw_ready,
  input  axi_slave_pkg::axi_cmd_t   aw,
  input  logic                      w_valid,
  output logic                      w_ready,
  input  axi_slave_pkg::axi_wbeat_t w,
  output logic                      b_valid,
  input  logic                      b_ready,
  output axi_slave_pkg::axi_bresp_t b,
  input  logic                      ar_valid,
  output logic                      ar_ready,
  input  axi_slave_pkg::axi_cmd_t   ar,
  output logic                      r_valid,
  input  logic                      r_ready,
  output axi_slave_pkg::axi_rbeat_t r
);

  logic        wr_en;
  logic [4:0]  wr_word;
  logic [31:0] wr_data;
  logic [3:0]  wr_strb;
  logic [4:0]  rd_word;
  logic [31:0] rd_data;

  axi_write_path u_write (
    .clk (clk), .resetn (resetn),
    .aw_valid (aw_valid), .aw_ready (aw_ready), .aw (aw),
    .w_valid (w_valid), .w_ready (w_ready), .w (w),
    .b_valid (b_valid), .b_ready (b_ready), .b (b),
    .wr_en (wr_en), .wr_word (wr_word), .wr_data (wr_data), .wr_strb (wr_strb)
  );

  axi_read_path u_read (
    .clk (clk), .resetn (resetn),
    .ar_valid (ar_valid), .ar_ready (ar_ready), .ar (ar),
    .r_valid (r_valid), .r_ready (r_ready), .r (r),
    .rd_word (rd_word), .rd_data (rd_data)
  );

  axi_byte_mem u_mem (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_word (wr_word),
    .wr_data (wr_data),
    .wr_strb (wr_strb),
    .rd_word (rd_word),
    .rd_data (rd_data)
  );

endmodule

// File: sim/axi_slave_ref.svh
// reference model for the AXI slave testbench, data prediction assumes beats of 4 bytes or less
`ifndef AXI_SLAVE_REF_SVH
`define AXI_SLAVE_REF_SVH

logic [7:0] shadow [axi_slave_pkg::mem_bytes];  // byte image of the DUT memory

// 32-bit LCG step
function automatic logic [31:0] lcg(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic axi_slave_pkg::axi_resp_e ref_resp(input axi_slave_pkg::axi_cmd_t c);
  logic wrap_len_ok;
  wrap_len_ok = (c.len == 4'd1) || (c.len == 4'd3) || (c.len == 4'd7) || (c.len == 4'd15);
  if (c.size > 3'd2 || c.burst == axi_slave_pkg::reserved) return axi_slave_pkg::slverr;
  if (c.burst == axi_slave_pkg::wrap && !wrap_len_ok) return axi_slave_pkg::slverr;
  if (c.addr >= 32'd128) return axi_slave_pkg::decerr;  // outside the memory
  return axi_slave_pkg::okay;
endfunction

// memory word hit by beat n of a burst
function automatic logic [4:0] ref_word(input axi_slave_pkg::axi_cmd_t c, input int n);
  logic [31:0] bytes;
  logic [31:0] block;
  logic [31:0] start;
  logic [31:0] a;
  bytes = 32'd1 << c.size;
  block = ({28'd0, c.len} + 32'd1) * bytes;  // wrap window
  start = c.addr - (c.addr % bytes);
  if (c.burst == axi_slave_pkg::fixed) a = start;
  else if (c.burst == axi_slave_pkg::wrap)
    a = start - (start % block) + ((start % block) + n * bytes) % block;
  else a = start + n * bytes;
  return a[6:2];  // low 7 bits, word aligned
endfunction

function automatic void shadow_write(input axi_slave_pkg::axi_cmd_t c, input int n,
                                     input logic [31:0] data, input logic [3:0] strb);
  logic [4:0] wd;
  wd = ref_word(c, n);
  for (int lane = 0; lane < 4; lane++) begin
    if (strb[lane]) shadow[4 * wd + lane] = data[8*lane +: 8];
  end
endfunction

function automatic logic [31:0] ref_rdata(input axi_slave_pkg::axi_cmd_t c, input int n,
                                          input axi_slave_pkg::axi_resp_e resp);
  logic [4:0] wd;
  wd = ref_word(c, n);
  if (resp != axi_slave_pkg::okay) return 32'd0;  // error beats carry zero data
  return {shadow[4*wd+3], shadow[4*wd+2], shadow[4*wd+1], shadow[4*wd]};
endfunction

`endif

// File: sim/axi_slave_tb.sv
// testbench for axi_slave_top, one write and one read in flight at most, stops at first error
`timescale 1ns/1ps
module axi_slave_tb;

  logic                      clk = 1'b0;
  logic                      resetn;
  logic                      aw_valid;
  logic                      aw_ready;
  logic                      w_valid;
  logic                      w_ready;
  logic                      b_valid;
  logic                      b_ready;
  logic                      ar_valid;
  logic                      ar_ready;
  logic                      r_valid;
  logic                      r_ready;
  axi_slave_pkg::axi_cmd_t   aw;
  axi_slave_pkg::axi_cmd_t   ar;
  axi_slave_pkg::axi_wbeat_t w;
  axi_slave_pkg::axi_bresp_t b;
  axi_slave_pkg::axi_rbeat_t r;
  axi_slave_pkg::axi_bresp_t exp_b [$];  // expected B, in order
  axi_slave_pkg::axi_rbeat_t exp_r [$];  // expected R beats, in order
  logic [31:0]               rnd_data = 32'he77c99db;
  logic [31:0]               rnd_ready;
  logic                      throttle = 1'b0;  // random gaps on W, B and R
  int                        cycles = 0;
  int                        b_done = 0;
  int                        r_done = 0;

  `include "axi_slave_ref.svh"

  axi_slave_top DUT (.*);

  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // failure reporting and compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string field, input logic [31:0] got,
                                 input logic [31:0] exp);
    stop_run($sformatf("mismatch at %0t ns: %s is %h, expected %h", $time, field, got, exp));
  endtask

  task automatic check_b(input axi_slave_pkg::axi_bresp_t got,
                         input axi_slave_pkg::axi_bresp_t exp);
    if (got.id !== exp.id) report_mismatch("B id", got.id, exp.id);
    else if (got.resp !== exp.resp) report_mismatch("B resp", got.resp, exp.resp);
  endtask

  task automatic check_r(input axi_slave_pkg::axi_rbeat_t got,
                         input axi_slave_pkg::axi_rbeat_t exp);
    if (got.id !== exp.id) report_mismatch("R id", got.id, exp.id);
    else if (got.data !== exp.data) report_mismatch("R data", got.data, exp.data);
    else if (got.resp !== exp.resp) report_mismatch("R resp", got.resp, exp.resp);
    else if (got.last !== exp.last) report_mismatch("R last", got.last, exp.last);
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) report_mismatch(name, got, exp);
  endtask

  always @(posedge clk) begin
    if (resetn && b_valid && b_ready) begin
      if (exp_b.size() == 0) begin
        stop_run("B response arrived with no write outstanding");
      end else begin
        check_b(b, exp_b.pop_front());
        b_done++;
      end
    end
    if (resetn && r_valid && r_ready) begin
      if (exp_r.size() == 0) begin
        stop_run("R beat arrived with no read beat outstanding");
      end else begin
        check_r(r, exp_r.pop_front());
        r_done++;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == 4000) stop_run("timeout: the test did not finish within 4000 cycles");
  end

  always @(negedge clk) begin
    rnd_ready = lcg(rnd_ready);
    b_ready = !throttle || rnd_ready[30];
    r_ready = !throttle || rnd_ready[27];
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////
  function automatic axi_slave_pkg::axi_cmd_t make_cmd(input int id, input logic [31:0] addr,
      input int len, input int size, input axi_slave_pkg::axi_burst_e burst);
    make_cmd = '{id: id[3:0], addr: addr, len: len[3:0], size: size[2:0], burst: burst};
  endfunction

  task automatic run_write(input axi_slave_pkg::axi_cmd_t c, input logic full);
    axi_slave_pkg::axi_resp_e   resp;
    axi_slave_pkg::axi_wbeat_t  beat;
    int                         target;
    resp = ref_resp(c);
    target = b_done + 1;
    exp_b.push_back('{id: c.id, resp: resp});
    @(negedge clk);
    aw = c;
    aw_valid = 1'b1;
    @(posedge clk);
    while (!aw_ready) @(posedge clk);
    @(negedge clk);
    aw_valid = 1'b0;
    for (int n = 0; n <= c.len; n++) begin
      rnd_data = lcg(rnd_data);
      beat.data = rnd_data;
      rnd_data = lcg(rnd_data);
      beat.strb = full ? 4'hf : rnd_data[31:28];
      beat.last = (n == c.len);
      if (resp == axi_slave_pkg::okay) shadow_write(c, n, beat.data, beat.strb);
      rnd_data = lcg(rnd_data);
      if (throttle && rnd_data[30]) @(negedge clk);  // W idle for a cycle
      w = beat;
      w_valid = 1'b1;
      @(posedge clk);
      while (!w_ready) @(posedge clk);
      @(negedge clk);
      w_valid = 1'b0;
    end
    wait (b_done == target);
  endtask

  task automatic run_read(input axi_slave_pkg::axi_cmd_t c);
    axi_slave_pkg::axi_resp_e resp;
    int                       target;
    resp = ref_resp(c);
    target = r_done + c.len + 1;
    for (int n = 0; n <= c.len; n++) begin
      exp_r.push_back('{id: c.id, data: ref_rdata(c, n, resp), resp: resp, last: (n == c.len)});
    end
    @(negedge clk);
    ar = c;
    ar_valid = 1'b1;
    @(posedge clk);
    while (!ar_ready) @(posedge clk);
    @(negedge clk);
    ar_valid = 1'b0;
    wait (r_done == target);
  endtask

  initial begin
    resetn = 1'b0;
    aw_valid = 1'b0;
    w_valid = 1'b0;
    ar_valid = 1'b0;
    b_ready = 1'b1;
    r_ready = 1'b1;
    aw = '0;
    ar = '0;
    w = '0;
    rnd_ready = lcg(32'he77c99db);
    repeat (4) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    // handshake levels out of reset
    compare_flag("aw_ready after reset", aw_ready, 1'b1);
    compare_flag("ar_ready after reset", ar_ready, 1'b1);
    compare_flag("w_ready after reset", w_ready, 1'b0);
    compare_flag("b_valid after reset", b_valid, 1'b0);
    compare_flag("r_valid after reset", r_valid, 1'b0);
    run_write(make_cmd(1, 32'h00, 15, 2, axi_slave_pkg::incr), 1'b1);  // fill all words
    run_write(make_cmd(2, 32'h40, 15, 2, axi_slave_pkg::incr), 1'b1);
    for (int len = 0; len < 16; len++) begin
      run_write(make_cmd(len, (len * 36) % 128, len, 2, axi_slave_pkg::incr), 1'b1);
      run_read(make_cmd(15 - len, (len * 36) % 128, len, 2, axi_slave_pkg::incr));
    end
    for (int k = 0; k < 6; k++) begin
      run_write(make_cmd(k, 32'h20 + 12 * k, 3, 2, axi_slave_pkg::incr), 1'b0);
      run_read(make_cmd(k + 6, 32'h20 + 12 * k, 3, 2, axi_slave_pkg::incr));
    end
    run_write(make_cmd(3, 32'h30, 3, 2, axi_slave_pkg::fixed), 1'b1);
    run_read(make_cmd(4, 32'h30, 5, 2, axi_slave_pkg::fixed));
    run_write(make_cmd(5, 32'h28, 3, 2, axi_slave_pkg::wrap), 1'b1);  // wraps inside 0x20..0x2f
    run_read(make_cmd(6, 32'h28, 3, 2, axi_slave_pkg::wrap));
    run_write(make_cmd(7, 32'h54, 7, 2, axi_slave_pkg::wrap), 1'b0);  // wraps inside 0x40..0x5f
    run_read(make_cmd(8, 32'h54, 7, 2, axi_slave_pkg::wrap));
    run_write(make_cmd(9, 32'h80, 2, 2, axi_slave_pkg::incr), 1'b1);
    run_read(make_cmd(10, 32'h100, 3, 2, axi_slave_pkg::incr));
    run_write(make_cmd(11, 32'h90, 1, 3, axi_slave_pkg::incr), 1'b1);
    run_read(make_cmd(12, 32'h10, 1, 3, axi_slave_pkg::incr));
    run_write(make_cmd(13, 32'h08, 2, 2, axi_slave_pkg::wrap), 1'b1);
    run_read(make_cmd(14, 32'h08, 2, 2, axi_slave_pkg::wrap));
    run_read(make_cmd(15, 32'h00, 7, 2, axi_slave_pkg::incr));  // errored writes left no trace
    throttle = 1'b1;
    for (int k = 0; k < 6; k++) begin
      fork
        run_write(make_cmd(k, 4 * k, 7, 2, axi_slave_pkg::incr), 1'b0);
        run_read(make_cmd(k + 8, 32'h40 + 4 * k, 7, 2, axi_slave_pkg::incr));
      join
    end
    throttle = 1'b0;
    run_read(make_cmd(1, 32'h00, 15, 2, axi_slave_pkg::incr));
    run_read(make_cmd(2, 32'h40, 15, 2, axi_slave_pkg::incr));
    if (exp_b.size() == 0 && exp_r.size() == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      stop_run("responses still outstanding at the end of the test");
    end
  end

endmodule

// File: flist.f
+incdir+sim
hdl/axi_slave_pkg.sv
hdl/axi_burst_addr.sv
hdl/axi_byte_mem.sv
hdl/axi_write_path.sv
hdl/axi_read_path.sv
hdl/axi_slave_top.sv
sim/axi_slave_tb.sv
